// ==== hdl/csb_pkg.sv ====
// configuration bus types and the register map of the vector engine
// shared by the APB bridge, the register block and the bench
package csb_pkg;

  // request from the bridge towards the register block
  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] wdat;
    logic        write;
    logic        nposted;
  } csb_req_t;

  // response, valid for reads and wr_complete for non-posted writes
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        wr_complete;
  } csb_rsp_t;

  //////////////////////////////////////////////////
  // register word addresses
  //////////////////////////////////////////////////
  localparam logic [15:0] reg_ctrl   = 16'd0;
  localparam logic [15:0] reg_status = 16'd1;
  localparam logic [15:0] reg_src    = 16'd2;
  localparam logic [15:0] reg_dst    = 16'd3;
  localparam logic [15:0] reg_len    = 16'd4;
  localparam logic [15:0] reg_bias   = 16'd5;

  // bit fields of ctrl and status
  localparam int ctrl_start_bit  = 0;
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

endpackage

// ==== hdl/dbb_pkg.sv ====
// data backbone widths, AXI-style channel payloads and the job
// configuration handed from the register block to the engine
package dbb_pkg;

  localparam int dbb_addr_w = 32;
  localparam int dbb_data_w = 64;

  // the engine works on 32-bit lanes of each backbone word
  localparam int dbb_lane_w = 32;
  localparam int dbb_lanes  = dbb_data_w / dbb_lane_w;

  //////////////////////////////////////////////////
  // channel payloads, valid and ready travel apart
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0]            id;
    logic [3:0]            len;
    logic [dbb_addr_w-1:0] addr;
  } dbb_ar_t;

  typedef struct packed {
    logic [7:0]            id;
    logic [3:0]            len;
    logic [dbb_addr_w-1:0] addr;
  } dbb_aw_t;

  typedef struct packed {
    logic [dbb_data_w-1:0]   data;
    logic [dbb_data_w/8-1:0] strb;
    logic                    last;
  } dbb_w_t;

  typedef struct packed {
    logic [7:0]            id;
    logic [dbb_data_w-1:0] data;
    logic                  last;
  } dbb_r_t;

  typedef struct packed {
    logic [7:0] id;
  } dbb_b_t;

  // len holds the word count minus one
  typedef struct packed {
    logic [dbb_addr_w-1:0] src;
    logic [dbb_addr_w-1:0] dst;
    logic [3:0]            len;
    logic [dbb_lane_w-1:0] bias;
  } job_cfg_t;

endpackage

// ==== hdl/apb2csb.sv ====
// APB slave to configuration bus bridge
// one APB access becomes one CSB transaction, pready marks its response
`timescale 1ns/10ps

module apb2csb (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [dbb_pkg::dbb_addr_w-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output csb_pkg::csb_req_t              csb_req,
  output logic                           csb_req_valid,
  input  logic                           csb_req_ready,
  input  csb_pkg::csb_rsp_t              csb_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_rsp
  } state_t;

  state_t state;
  logic   access;
  logic   rsp_hit;

  // pready still high means the master is in its closing access cycle
  assign access = psel && penable && !pready;

  // a write completes on wr_complete, a read on valid
  assign rsp_hit = csb_req.write ? csb_rsp.wr_complete : csb_rsp.valid;

  assign csb_req_valid = (state == st_req);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      pready <= 1'b0;
    end else begin
      pready <= 1'b0;
      case (state)
        st_idle: begin
          if (access) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (csb_req_ready) begin
            state <= st_rsp;
          end
        end
        st_rsp: begin
          if (rsp_hit) begin
            state  <= st_idle;
            pready <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request fields are taken in the first access cycle
  always_ff @(posedge clk) begin
    if (state == st_idle && access) begin
      csb_req.addr    <= paddr[17:2];
      csb_req.wdat    <= pwdata;
      csb_req.write   <= pwrite;
      csb_req.nposted <= pwrite;
    end
    if (state == st_rsp && rsp_hit) begin
      prdata <= csb_rsp.data;
    end
  end

endmodule

// ==== hdl/dla_regs.sv ====
// register file of the vector engine on the configuration bus
// holds the job setup, issues the start pulse and owns done and intr
`timescale 1ns/10ps

module dla_regs (
  input  logic              clk,
  input  logic              reset,
  input  csb_pkg::csb_req_t csb_req,
  input  logic              csb_req_valid,
  output logic              csb_req_ready,
  output csb_pkg::csb_rsp_t csb_rsp,
  output dbb_pkg::job_cfg_t job_cfg,
  output logic              start_pulse,
  input  logic              busy,
  input  logic              job_done,
  output logic              intr
);

  import csb_pkg::*;

  logic        wr_en;
  logic        rd_en;
  logic        start_req;
  logic        done;
  logic        done_clr;
  logic [31:0] rd_data;

  // every request is taken at once
  assign csb_req_ready = 1'b1;

  assign wr_en = csb_req_valid && csb_req.write;
  assign rd_en = csb_req_valid && !csb_req.write;

  assign start_req = wr_en && (csb_req.addr == reg_ctrl) && csb_req.wdat[ctrl_start_bit];
  assign done_clr  = wr_en && (csb_req.addr == reg_status) && csb_req.wdat[status_done_bit];

  assign intr = done;

  //////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    case (csb_req.addr)
      reg_status: begin
        rd_data[status_busy_bit] = busy;
        rd_data[status_done_bit] = done;
      end
      reg_src:  rd_data = job_cfg.src;
      reg_dst:  rd_data = job_cfg.dst;
      reg_len:  rd_data[3:0] = job_cfg.len;
      reg_bias: rd_data = job_cfg.bias;
      // ctrl and unmapped words read zero
      default:  rd_data = '0;
    endcase
  end

  // job configuration
  always_ff @(posedge clk) begin
    if (reset) begin
      job_cfg <= '0;
    end else if (wr_en) begin
      case (csb_req.addr)
        reg_src:  job_cfg.src  <= csb_req.wdat;
        reg_dst:  job_cfg.dst  <= csb_req.wdat;
        reg_len:  job_cfg.len  <= csb_req.wdat[3:0];
        reg_bias: job_cfg.bias <= csb_req.wdat;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // start, done flag and response
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      start_pulse <= 1'b0;
      done        <= 1'b0;
      csb_rsp     <= '0;
    end else begin
      // a start while the engine runs is dropped
      start_pulse <= start_req && !busy;

      // software clear beats a finishing job in the same cycle
      if (done_clr) begin
        done <= 1'b0;
      end else if (job_done) begin
        done <= 1'b1;
      end

      csb_rsp.valid       <= rd_en;
      csb_rsp.wr_complete <= wr_en && csb_req.nposted;
      csb_rsp.data        <= rd_en ? rd_data : '0;
    end
  end

endmodule

// ==== hdl/dla_dma.sv ====
// single-burst job engine on the data backbone
// reads 1 to 16 words, adds the bias to every 32-bit lane into a local
// buffer, writes the buffer back as one burst and pulses job_done
`timescale 1ns/10ps

module dla_dma #(
  parameter logic [7:0] dbb_id = 8'h2a
) (
  input  logic              clk,
  input  logic              reset,
  input  dbb_pkg::job_cfg_t job_cfg,
  input  logic              start_pulse,
  output logic              busy,
  output logic              job_done,
  output dbb_pkg::dbb_ar_t  ar,
  output logic              ar_valid,
  input  logic              ar_ready,
  input  dbb_pkg::dbb_r_t   r,
  input  logic              r_valid,
  output logic              r_ready,
  output dbb_pkg::dbb_aw_t  aw,
  output logic              aw_valid,
  input  logic              aw_ready,
  output dbb_pkg::dbb_w_t   w,
  output logic              w_valid,
  input  logic              w_ready,
  input  dbb_pkg::dbb_b_t   b,
  input  logic              b_valid,
  output logic              b_ready
);

  import dbb_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_ar,
    st_r,
    st_aw,
    st_w,
    st_b
  } state_t;

  state_t                state;
  job_cfg_t              cfg_q;
  logic [dbb_data_w-1:0] buf_mem [16];
  logic [3:0]            rd_cnt;
  logic [3:0]            wr_cnt;
  logic                  r_hit;
  logic                  b_hit;
  logic                  w_last;

  // lane-wise add, each lane wraps on its own
  function automatic logic [dbb_data_w-1:0] add_bias(
    input logic [dbb_data_w-1:0] data,
    input logic [dbb_lane_w-1:0] bias
  );
    logic [dbb_data_w-1:0] sum;
    for (int i = 0; i < dbb_lanes; i++) begin
      sum[i*dbb_lane_w +: dbb_lane_w] = data[i*dbb_lane_w +: dbb_lane_w] + bias;
    end
    return sum;
  endfunction

  assign busy = (state != st_idle);

  //////////////////////////////////////////////////
  // channel drive
  //////////////////////////////////////////////////
  assign ar_valid = (state == st_ar);
  assign ar       = '{id: dbb_id, len: cfg_q.len, addr: cfg_q.src};

  // beats carrying a foreign id are not ours
  assign r_ready = (state == st_r);
  assign r_hit   = r_ready && r_valid && (r.id == dbb_id);

  assign aw_valid = (state == st_aw);
  assign aw       = '{id: dbb_id, len: cfg_q.len, addr: cfg_q.dst};

  assign w_last  = (wr_cnt == cfg_q.len);
  assign w_valid = (state == st_w);
  assign w       = '{data: buf_mem[wr_cnt], strb: {(dbb_data_w/8){1'b1}}, last: w_last};

  assign b_ready  = (state == st_b);
  assign b_hit    = b_ready && b_valid && (b.id == dbb_id);
  assign job_done = b_hit;

  //////////////////////////////////////////////////
  // job sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start_pulse) begin
            state  <= st_ar;
            rd_cnt <= '0;
            wr_cnt <= '0;
          end
        end
        st_ar: begin
          if (ar_ready) begin
            state <= st_r;
          end
        end
        st_r: begin
          if (r_hit) begin
            rd_cnt <= rd_cnt + 4'd1;
            if (r.last) begin
              state <= st_aw;
            end
          end
        end
        st_aw: begin
          if (aw_ready) begin
            state <= st_w;
          end
        end
        st_w: begin
          if (w_ready) begin
            if (w_last) begin
              state <= st_b;
            end else begin
              wr_cnt <= wr_cnt + 4'd1;
            end
          end
        end
        st_b: begin
          if (b_hit) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // configuration is frozen for the whole job
  always_ff @(posedge clk) begin
    if (state == st_idle && start_pulse) begin
      cfg_q <= job_cfg;
    end
    if (r_hit) begin
      buf_mem[rd_cnt] <= add_bias(r.data, cfg_q.bias);
    end
  end

endmodule

// ==== hdl/dla_wrapper.sv ====
// top level of the vector engine
// APB slave in, AXI-style backbone master out, level interrupt
`timescale 1ns/10ps

module dla_wrapper #(
  parameter logic [7:0] dbb_id = 8'h2a
) (
  input  logic                           clk,
  input  logic                           reset,
  // APB slave
  input  logic [dbb_pkg::dbb_addr_w-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  // data backbone master
  output dbb_pkg::dbb_ar_t               ar,
  output logic                           ar_valid,
  input  logic                           ar_ready,
  input  dbb_pkg::dbb_r_t                r,
  input  logic                           r_valid,
  output logic                           r_ready,
  output dbb_pkg::dbb_aw_t               aw,
  output logic                           aw_valid,
  input  logic                           aw_ready,
  output dbb_pkg::dbb_w_t                w,
  output logic                           w_valid,
  input  logic                           w_ready,
  input  dbb_pkg::dbb_b_t                b,
  input  logic                           b_valid,
  output logic                           b_ready,
  // level high, cleared through status
  output logic                           intr
);

  import csb_pkg::*;
  import dbb_pkg::*;

  csb_req_t csb_req;
  csb_rsp_t csb_rsp;
  logic     csb_req_valid;
  logic     csb_req_ready;
  job_cfg_t job_cfg;
  logic     start_pulse;
  logic     busy;
  logic     job_done;

  // the register block never flags an error
  assign pslverr = 1'b0;

  //////////////////////////////////////////////////
  // configuration path
  //////////////////////////////////////////////////
  apb2csb u_apb2csb (
    .clk           (clk),
    .reset         (reset),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .csb_req       (csb_req),
    .csb_req_valid (csb_req_valid),
    .csb_req_ready (csb_req_ready),
    .csb_rsp       (csb_rsp)
  );

  dla_regs u_dla_regs (
    .clk           (clk),
    .reset         (reset),
    .csb_req       (csb_req),
    .csb_req_valid (csb_req_valid),
    .csb_req_ready (csb_req_ready),
    .csb_rsp       (csb_rsp),
    .job_cfg       (job_cfg),
    .start_pulse   (start_pulse),
    .busy          (busy),
    .job_done      (job_done),
    .intr          (intr)
  );

  // job engine on the backbone
  dla_dma #(
    .dbb_id (dbb_id)
  ) u_dla_dma (
    .clk         (clk),
    .reset       (reset),
    .job_cfg     (job_cfg),
    .start_pulse (start_pulse),
    .busy        (busy),
    .job_done    (job_done),
    .ar          (ar),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r           (r),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .aw          (aw),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .w           (w),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .b           (b),
    .b_valid     (b_valid),
    .b_ready     (b_ready)
  );

endmodule

// ==== bench/tb_dbb_mem.sv ====
// backbone memory model with one read and one write burst in flight
// ready and valid stall at random, words are preloaded through a fill port
`timescale 1ns/10ps

module tb_dbb_mem (
  input  logic             clk,
  input  logic             fill_en,
  input  logic [7:0]       fill_idx,
  input  logic [63:0]      fill_data,
  input  dbb_pkg::dbb_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  output dbb_pkg::dbb_r_t  r,
  output logic             r_valid,
  input  logic             r_ready,
  input  dbb_pkg::dbb_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  dbb_pkg::dbb_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  output dbb_pkg::dbb_b_t  b,
  output logic             b_valid,
  input  logic             b_ready
);

  // 256 words, byte address bits 10:3 pick the word
  logic [63:0] mem [256];
  logic [31:0] rng = 32'd82;
  logic [7:0]  rd_idx;
  logic [7:0]  wr_idx;
  logic [7:0]  rd_id;
  logic [7:0]  wr_id;
  logic [3:0]  rd_left;
  logic        rd_active;
  logic        wr_active;
  logic        b_pending;
  logic        r_hs;
  logic        b_hs;

  // xorshift step, a channel stalls one cycle in four
  function automatic logic no_stall();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng[1:0] != 2'b00;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
    end
    rd_idx    = '0;
    wr_idx    = '0;
    rd_id     = '0;
    wr_id     = '0;
    rd_left   = '0;
    rd_active = 1'b0;
    wr_active = 1'b0;
    b_pending = 1'b0;
    ar_ready  = 1'b0;
    r         = '0;
    r_valid   = 1'b0;
    aw_ready  = 1'b0;
    w_ready   = 1'b0;
    b         = '0;
    b_valid   = 1'b0;
    forever begin
      // handshakes are taken mid-cycle, where every signal is settled
      @(negedge clk);
      r_hs = r_valid && r_ready;
      b_hs = b_valid && b_ready;
      if (fill_en) begin
        mem[fill_idx] = fill_data;
      end
      if (ar_valid && ar_ready) begin
        rd_active = 1'b1;
        rd_idx    = ar.addr[10:3];
        rd_left   = ar.len;
        rd_id     = ar.id;
      end
      if (r_hs) begin
        if (rd_left == 4'd0) begin
          rd_active = 1'b0;
        end else begin
          rd_idx++;
          rd_left--;
        end
      end
      if (aw_valid && aw_ready) begin
        wr_active = 1'b1;
        wr_idx    = aw.addr[10:3];
        wr_id     = aw.id;
      end
      if (w_valid && w_ready) begin
        mem[wr_idx] = w.data;
        wr_idx++;
        if (w.last) begin
          wr_active = 1'b0;
          b_pending = 1'b1;
        end
      end
      if (b_hs) begin
        b_pending = 1'b0;
      end

      @(posedge clk);
      #2;
      ar_ready = !rd_active && no_stall();
      // a raised valid stays up until it is taken
      if (!r_valid || r_hs) begin
        r_valid = rd_active && no_stall();
      end
      r        = '{id: rd_id, data: mem[rd_idx], last: (rd_left == 4'd0)};
      aw_ready = !wr_active && !b_pending && no_stall();
      w_ready  = wr_active && no_stall();
      if (!b_valid || b_hs) begin
        b_valid = b_pending && no_stall();
      end
      b = '{id: wr_id};
    end
  end

endmodule

// ==== bench/tb_checker.sv ====
// watches the DUT ports and predicts each written beat from the read beats
// and the bias written over APB, counts errors and write bursts
`timescale 1ns/10ps

module tb_checker #(
  parameter logic [7:0] dbb_id = 8'h2a
) (
  input  logic                           clk,
  input  logic [dbb_pkg::dbb_addr_w-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  input  logic                           pready,
  input  dbb_pkg::dbb_ar_t               ar,
  input  logic                           ar_valid,
  input  logic                           ar_ready,
  input  dbb_pkg::dbb_r_t                r,
  input  logic                           r_valid,
  input  logic                           r_ready,
  input  dbb_pkg::dbb_aw_t               aw,
  input  logic                           aw_valid,
  input  logic                           aw_ready,
  input  dbb_pkg::dbb_w_t                w,
  input  logic                           w_valid,
  input  logic                           w_ready,
  input  logic                           intr,
  output int                             err_count,
  output int                             burst_count
);

  import csb_pkg::*;
  import dbb_pkg::*;

  logic [31:0] cur_bias = '0;
  logic [31:0] cur_dst = '0;
  logic [31:0] cur_src = '0;
  logic [3:0]  cur_len = '0;
  logic [31:0] job_bias = '0;
  logic [63:0] exp_q [$];
  logic [63:0] exp_word;
  logic [3:0]  beat_idx = '0;
  logic [3:0]  burst_len = '0;
  logic        intr_armed = 1'b0;
  int          intr_wait = 0;
  int          errors = 0;
  int          bursts = 0;

  assign err_count   = errors;
  assign burst_count = bursts;

  // expected beat is each 32-bit lane plus bias modulo 2^32
  function automatic logic [63:0] biased_word(input logic [63:0] word,
                                              input logic [31:0] bias);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = word[63:32] + bias;
    lo = word[31:0] + bias;
    return {hi, lo};
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
    errors++;
  endtask

  always @(negedge clk) begin
    // APB writes count in their completing cycle
    if (psel && penable && pready && pwrite) begin
      if (paddr[17:2] == reg_bias) begin
        cur_bias = pwdata;
      end
      if (paddr[17:2] == reg_dst) begin
        cur_dst = pwdata;
      end
      if (paddr[17:2] == reg_src) begin
        cur_src = pwdata;
      end
      if (paddr[17:2] == reg_len) begin
        cur_len = pwdata[3:0];
      end
    end
    if (ar_valid && ar_ready) begin
      job_bias = cur_bias;
      exp_q.delete();
      if (ar.id !== dbb_id) begin
        report_mismatch("ar id", 64'(ar.id), 64'(dbb_id));
      end
      if (ar.addr !== cur_src) begin
        report_mismatch("ar addr", 64'(ar.addr), 64'(cur_src));
      end
      if (ar.len !== cur_len) begin
        report_mismatch("ar len", 64'(ar.len), 64'(cur_len));
      end
    end
    if (r_valid && r_ready) begin
      exp_q.push_back(biased_word(r.data, job_bias));
    end
    if (aw_valid && aw_ready) begin
      bursts++;
      beat_idx  = '0;
      burst_len = cur_len;
      if (aw.id !== dbb_id) begin
        report_mismatch("aw id", 64'(aw.id), 64'(dbb_id));
      end
      if (aw.addr !== cur_dst) begin
        report_mismatch("aw addr", 64'(aw.addr), 64'(cur_dst));
      end
      if (aw.len !== cur_len) begin
        report_mismatch("aw len", 64'(aw.len), 64'(cur_len));
      end
    end

    //////////////////////////////////////////////////
    // write beats
    //////////////////////////////////////////////////
    if (w_valid && w_ready) begin
      if (exp_q.size() == 0) begin
        $display("write beat %0d arrived with no read beat left to match it", beat_idx);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        if (w.data !== exp_word) begin
          report_mismatch("w data", w.data, exp_word);
        end
      end
      if (w.strb !== 8'hff) begin
        report_mismatch("w strb", 64'(w.strb), 64'hff);
      end
      if (beat_idx == burst_len && !w.last) begin
        $display("write burst of %0d beats ended without last", int'(burst_len) + 1);
        errors++;
      end else if (beat_idx != burst_len && w.last) begin
        $display("last came early, on beat %0d of a %0d-beat burst",
                 beat_idx, int'(burst_len) + 1);
        errors++;
      end
      if (beat_idx == burst_len) begin
        intr_armed = 1'b1;
        intr_wait  = 0;
      end
      beat_idx++;
    end

    // intr has to follow the final beat within a few dozen cycles
    if (intr_armed) begin
      if (intr) begin
        intr_armed = 1'b0;
      end else if (intr_wait == 60) begin
        $display("interrupt never arrived after the write burst finished");
        errors++;
        intr_armed = 1'b0;
      end else begin
        intr_wait++;
      end
    end
  end

endmodule

// ==== bench/tb_top.sv ====
// testbench top for the vector engine
// programs jobs over APB, the memory model answers the backbone and the
// checker compares every written beat against its own prediction
`timescale 1ns/10ps

module tb_top;

  import csb_pkg::*;
  import dbb_pkg::*;

  localparam logic [7:0] engine_id      = 8'h5c;
  localparam int         max_jobs       = 25;
  localparam int         cycles_per_job = 400;

  logic                  clk = 1'b0;
  logic                  reset;
  logic [dbb_addr_w-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  dbb_ar_t               ar;
  logic                  ar_valid;
  logic                  ar_ready;
  dbb_r_t                r;
  logic                  r_valid;
  logic                  r_ready;
  dbb_aw_t               aw;
  logic                  aw_valid;
  logic                  aw_ready;
  dbb_w_t                w;
  logic                  w_valid;
  logic                  w_ready;
  dbb_b_t                b;
  logic                  b_valid;
  logic                  b_ready;
  logic                  intr;
  logic                  fill_en;
  logic [7:0]            fill_idx;
  logic [63:0]           fill_data;
  int                    chk_errors;
  int                    bursts;
  int                    errors = 0;
  int                    jobs = 0;
  logic [31:0]           rng = 32'd82;

  always #20 clk = ~clk;

  dla_wrapper #(.dbb_id(engine_id)) dut (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .intr(intr)
  );

  tb_dbb_mem u_mem (
    .clk(clk), .fill_en(fill_en), .fill_idx(fill_idx), .fill_data(fill_data),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .b(b), .b_valid(b_valid), .b_ready(b_ready)
  );

  tb_checker #(.dbb_id(engine_id)) u_checker (
    .clk(clk), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .pready(pready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready),
    .intr(intr), .err_count(chk_errors), .burst_count(bursts)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  //////////////////////////////////////////////////
  // APB master, every task starts and ends 2 ns after a rising edge
  //////////////////////////////////////////////////
  task automatic apb_access(input logic write, input logic [15:0] word,
                            input logic [31:0] data, output logic [31:0] rdata);
    int cycles;
    paddr   = {14'd0, word, 2'b00};
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    cycles  = 0;
    while (!pready && cycles < 20) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!pready) begin
      $display("APB access to register %0d got no pready", word);
      errors++;
    end
    rdata = prdata;
    if (pslverr !== 1'b0) begin
      $display("FAILED at %0d ns: pslverr high on register %0d", $time, word);
      errors++;
    end
    // master holds the access through the edge that sees pready
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] word, input logic [31:0] data);
    logic [31:0] unused_rdata;
    apb_access(1'b1, word, data, unused_rdata);
  endtask

  task automatic check_read(input logic [15:0] word, input logic [31:0] expected);
    logic [31:0] data;
    apb_access(1'b0, word, 32'd0, data);
    if (data !== expected) begin
      $display("FAILED at %0d ns: register %0d reads %h, expected %h",
               $time, word, data, expected);
      errors++;
    end
  endtask

  // one memory word per cycle through the preload port
  task automatic load_word(input logic [7:0] idx, input logic [63:0] data);
    fill_idx  = idx;
    fill_data = data;
    fill_en   = 1'b1;
    @(posedge clk);
    #2;
    fill_en   = 1'b0;
  endtask

  task automatic fill_source(input logic [31:0] src, input logic [3:0] len);
    logic [31:0] hi;
    for (int k = 0; k <= int'(len); k++) begin
      hi = next_rand();
      load_word(src[10:3] + 8'(k), {hi, next_rand()});
    end
  endtask

  task automatic program_job(input logic [31:0] src, input logic [31:0] dst,
                             input logic [3:0] len, input logic [31:0] bias);
    apb_write(reg_src, src);
    apb_write(reg_dst, dst);
    apb_write(reg_len, {28'd0, len});
    apb_write(reg_bias, bias);
    apb_write(reg_ctrl, 32'h1);
    jobs++;
  endtask

  // wait for intr, then clear done through status
  task automatic finish_job();
    int cycles;
    cycles = 0;
    while (!intr && cycles < cycles_per_job) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!intr) begin
      $display("job %0d raised no interrupt within %0d cycles", jobs, cycles_per_job);
      errors++;
    end
    check_read(reg_status, 32'h2);
    apb_write(reg_status, 32'h2);
    if (intr !== 1'b0) begin
      $display("FAILED at %0d ns: intr still high after done was cleared", $time);
      errors++;
    end
    check_read(reg_status, 32'h0);
  endtask

  initial begin
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] pick;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    fill_en   = 1'b0;
    fill_idx  = '0;
    fill_data = '0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    // register read-back and an unmapped word
    apb_write(reg_src, 32'h0000_0a08);
    apb_write(reg_dst, 32'h1234_5678);
    apb_write(reg_len, 32'h0000_0007);
    apb_write(reg_bias, 32'hdead_beef);
    check_read(reg_src, 32'h0000_0a08);
    check_read(reg_dst, 32'h1234_5678);
    check_read(reg_len, 32'h0000_0007);
    check_read(reg_bias, 32'hdead_beef);
    check_read(16'd9, 32'h0);
    check_read(reg_status, 32'h0);

    // single word, the upper lane wraps
    load_word(8'h20, {32'hffff_ff00, 32'h0000_0020});
    program_job(32'h100, 32'h400, 4'd0, 32'h0000_0200);
    finish_job();

    // full 16-word burst
    fill_source(32'h200, 4'hf);
    program_job(32'h200, 32'h600, 4'hf, next_rand());
    finish_job();

    // busy status and a start that must be dropped
    fill_source(32'h000, 4'hf);
    program_job(32'h000, 32'h700, 4'hf, next_rand());
    check_read(reg_status, 32'h1);
    apb_write(reg_ctrl, 32'h1);
    finish_job();

    //////////////////////////////////////////////////
    // back-to-back random jobs
    //////////////////////////////////////////////////
    for (int j = 0; j < 20; j++) begin
      pick = next_rand();
      src  = {21'd0, pick[10:3], 3'd0};
      dst  = {21'd0, pick[26:19], 3'd0};
      fill_source(src, pick[14:11]);
      program_job(src, dst, pick[14:11], next_rand());
      finish_job();
    end

    if (bursts != jobs) begin
      $display("expected %0d write bursts, the DUT made %0d", jobs, bursts);
      errors++;
    end
    $display("errors: bench %0d, checker %0d", errors, chk_errors);
    if (errors == 0 && chk_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized for the longest run of jobs
  initial begin
    repeat (max_jobs * cycles_per_job) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", max_jobs * cycles_per_job);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/csb_pkg.sv
hdl/dbb_pkg.sv
hdl/apb2csb.sv
hdl/dla_regs.sv
hdl/dla_dma.sv
hdl/dla_wrapper.sv
bench/tb_dbb_mem.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
